// File: filelist.f
+incdir+dv
design/ps2_key_pkg.sv
design/abc80_key_pkg.sv
design/key_decoder.sv
design/key_history.sv
design/abc80_keyboard.sv
dv/abc80_keyboard_tb.sv

// File: dv/key_stim_table.svh
/*
 * Key event table for the ABC80 keyboard testbench
 * One row per PS/2 event with the expected decoder result
 */

// Columns: pressed, extended, scan code, mapped, ABC80 code, upcase after, test name
add_row(1'b1, 1'b0, 8'h1C, 1'b1, 7'h61, 1'b0, "a_down_lower");
add_row(1'b0, 1'b0, 8'h1C, 1'b1, 7'h61, 1'b0, "a_up_lower");
add_row(1'b1, 1'b0, ps2_key_pkg::SC_LSHIFT, 1'b0, 7'h00, 1'b0, "lshift_down");
add_row(1'b1, 1'b0, 8'h1C, 1'b1, 7'h41, 1'b0, "a_down_shifted");
add_row(1'b0, 1'b0, 8'h1C, 1'b1, 7'h41, 1'b0, "a_up_shifted");
add_row(1'b1, 1'b0, ps2_key_pkg::SC_CAPS, 1'b0, 7'h00, 1'b1, "caps_down_toggles");
add_row(1'b0, 1'b0, ps2_key_pkg::SC_CAPS, 1'b0, 7'h00, 1'b1, "caps_up_keeps");
add_row(1'b1, 1'b0, 8'h32, 1'b1, 7'h62, 1'b1, "b_caps_and_shift");
add_row(1'b1, 1'b0, 8'h3D, 1'b1, 7'h2F, 1'b1, "shift_7_slash");
add_row(1'b0, 1'b0, ps2_key_pkg::SC_LSHIFT, 1'b0, 7'h00, 1'b1, "lshift_up");
add_row(1'b1, 1'b0, 8'h16, 1'b1, 7'h31, 1'b1, "digit_1");
add_row(1'b1, 1'b0, 8'h6B, 1'b1, 7'h34, 1'b1, "keypad_4");
add_row(1'b1, 1'b0, ps2_key_pkg::SC_ENTER, 1'b1, abc80_key_pkg::CH_CR, 1'b1, "enter");
add_row(1'b1, 1'b0, ps2_key_pkg::SC_SPACE, 1'b1, 7'h20, 1'b1, "space");
add_row(1'b1, 1'b1, ps2_key_pkg::SC_LEFT, 1'b1, abc80_key_pkg::CH_BS, 1'b1, "left_arrow");
add_row(1'b1, 1'b1, ps2_key_pkg::SC_RIGHT, 1'b1, abc80_key_pkg::CH_TAB, 1'b1, "right_arrow");
add_row(1'b1, 1'b0, ps2_key_pkg::SC_CTRL, 1'b0, 7'h00, 1'b1, "ctrl_down");
add_row(1'b1, 1'b0, 8'h21, 1'b1, abc80_key_pkg::CH_ETX, 1'b1, "ctrl_c");
add_row(1'b1, 1'b0, 8'h22, 1'b1, abc80_key_pkg::CH_CAN, 1'b1, "ctrl_x");
add_row(1'b1, 1'b0, 8'h1C, 1'b1, abc80_key_pkg::CH_SOH, 1'b1, "ctrl_a");
add_row(1'b0, 1'b0, 8'h1C, 1'b1, abc80_key_pkg::CH_SOH, 1'b1, "ctrl_a_up");
add_row(1'b0, 1'b0, 8'h1C, 1'b1, abc80_key_pkg::CH_SOH, 1'b1, "repeat_no_entry");
add_row(1'b0, 1'b0, ps2_key_pkg::SC_CTRL, 1'b0, 7'h00, 1'b1, "ctrl_up");
add_row(1'b1, 1'b0, 8'h1C, 1'b1, 7'h41, 1'b1, "a_down_caps");
add_row(1'b1, 1'b0, 8'h32, 1'b1, 7'h42, 1'b1, "b_over_a_release");
add_row(1'b1, 1'b0, 8'h07, 1'b0, 7'h00, 1'b1, "unmapped_no_entry");

// File: dv/abc80_keyboard_tb.sv
/*
 * ABC80 keyboard path testbench
 * Applies a table of PS/2 events and follows the paced key port
 * against a model of the key state and history ring
 */

`timescale 1ns/1ps
`default_nettype none

module abc80_keyboard_tb;

	localparam int PORT_WAIT = 300;            // Cycles per expected entry

	typedef struct packed {
		ps2_key_pkg::ps2_key_t key;
		logic                  mapped;
		logic [6:0]            code;
		logic                  caps;
	} stim_row_t;

	logic                      CLK12;
	logic                      RESET;
	logic                      key_strobe;
	ps2_key_pkg::ps2_key_t     key_in;
	abc80_key_pkg::key_entry_t key_port;
	logic                      upcase;

	stim_row_t                 rows[$];
	string                     names[$];
	abc80_key_pkg::key_entry_t expected[$];
	abc80_key_pkg::key_entry_t model_entry;    // Last entry the ring wrote
	abc80_key_pkg::key_entry_t shown;
	abc80_key_pkg::key_entry_t seen;
	int                        errors = 0;
	int                        failed = 0;
	int                        cycles = 0;
	int                        errs_before;

	abc80_keyboard dut_i (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),
		.key_in     (key_in),
		.key_port   (key_port),
		.upcase     (upcase)
	);

	initial begin
		CLK12 = 1'b0;
		forever #5 CLK12 = ~CLK12;
	end

	// ========================================================================
	// Table, model and checks
	// ========================================================================

	task automatic add_row(input logic pressed, input logic extended, input logic [7:0] code,
			input logic mapped, input logic [6:0] exp_code, input logic exp_caps,
			input string name);
		stim_row_t row;
		row.key.pressed = pressed;
		row.key.extended = extended;
		row.key.code = code;
		row.mapped = mapped;
		row.code = exp_code;
		row.caps = exp_caps;
		rows.push_back(row);
		names.push_back(name);
	endtask

	task automatic build_table;
		`include "key_stim_table.svh"
	endtask

	// Unmapped keys keep the key state, which then matches the last entry
	task automatic predict_entries(input stim_row_t row);
		abc80_key_pkg::key_entry_t next;
		abc80_key_pkg::key_entry_t release_entry;
		next = model_entry;
		if (row.mapped) begin
			next.down = row.key.pressed;
			next.code = row.code;
		end
		if (next != model_entry) begin
			if (next.down && model_entry.down) begin
				release_entry.down = 1'b0;         // Synthetic key up
				release_entry.code = model_entry.code;
				expected.push_back(release_entry);
			end
			expected.push_back(next);
			model_entry = next;
		end
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			$display("Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic apply_event(input ps2_key_pkg::ps2_key_t key);
		@(posedge CLK12);
		#1;
		key_strobe = 1'b1;
		key_in = key;
		@(posedge CLK12);
		#1;
		key_strobe = 1'b0;
		repeat (4) @(posedge CLK12);           // Idle gap
	endtask

	// Returns the first value different from from, or from itself after PORT_WAIT cycles
	task automatic watch_port(input abc80_key_pkg::key_entry_t from,
			output abc80_key_pkg::key_entry_t value);
		int n;
		n = 0;
		@(negedge CLK12);
		while (key_port == from && n < PORT_WAIT) begin
			@(negedge CLK12);
			n++;
		end
		value = key_port;
	endtask

	always @(posedge CLK12) begin
		cycles++;
		if (cycles >= rows.size() * 2 * PORT_WAIT + 100) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		RESET = 1'b1;
		key_strobe = 1'b0;
		key_in = '0;
		model_entry = '0;
		shown = '0;
		build_table();
		repeat (8) @(posedge CLK12);
		#1;
		RESET = 1'b0;
		@(negedge CLK12);
		check_value("key_port", key_port, 8'h00);
		check_value("upcase", upcase, 8'h00);
		$display("reset: %s", errors == 0 ? "ok" : "failed");
		failed += (errors != 0);

		for (int i = 0; i < rows.size(); i++) begin
			errs_before = errors;
			predict_entries(rows[i]);
			apply_event(rows[i].key);
			@(negedge CLK12);
			check_value("upcase", upcase, rows[i].caps);
			if (expected.size() == 0) begin
				watch_port(shown, seen);           // Port must stay put
				check_value("key_port", seen, shown);
			end
			while (expected.size() > 0) begin
				watch_port(shown, seen);
				if (seen == shown) begin
					$display("Error at %0t ns: key_port did not change within %0d cycles",
						$time, PORT_WAIT);
					errors++;
				end else
					check_value("key_port", seen, expected[0]);
				shown = expected.pop_front();
			end
			$display("%s: %s", names[i], errors == errs_before ? "ok" : "failed");
			failed += (errors != errs_before);
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			rows.size() + 1, rows.size() + 1 - failed, failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/abc80_keyboard.sv
/*
 * ABC80 keyboard path, top level
 * PS/2 key events in, paced key port and caps state out
 */

`timescale 1ns/1ps
`default_nettype none

module abc80_keyboard (
	input  logic                      CLK12,
	input  logic                      RESET,
	input  logic                      key_strobe,
	input  ps2_key_pkg::ps2_key_t     key_in,
	output abc80_key_pkg::key_entry_t key_port,
	output logic                      upcase
);

	abc80_key_pkg::key_entry_t key_state;
	logic                      key_update;

	key_decoder decoder_i (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),
		.key_in     (key_in),
		.key_state  (key_state),
		.key_update (key_update),
		.upcase     (upcase)
	);

	key_history history_i (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_state  (key_state),
		.key_update (key_update),
		.key_port   (key_port)
	);

endmodule

`default_nettype wire

// File: design/key_history.sv
/*
 * ABC80 key history ring
 * Eight entries of key state changes, with a release inserted between
 * two presses, read out slowly so the CPU sees every entry
 */

`timescale 1ns/1ps
`default_nettype none

module key_history (
	input  logic                      CLK12,
	input  logic                      RESET,
	input  abc80_key_pkg::key_entry_t key_state,
	input  logic                      key_update,
	output abc80_key_pkg::key_entry_t key_port
);

	abc80_key_pkg::key_entry_t ring [abc80_key_pkg::HIST_DEPTH];
	abc80_key_pkg::key_entry_t last_entry;
	abc80_key_pkg::key_entry_t release_entry;

	logic [abc80_key_pkg::HIST_IDX_W-1:0]  wr_idx;  // Last written slot
	logic [abc80_key_pkg::HIST_IDX_W-1:0]  rd_idx;
	logic [abc80_key_pkg::HIST_IDX_W-1:0]  wr_next1;
	logic [abc80_key_pkg::HIST_IDX_W-1:0]  wr_next2;
	logic [abc80_key_pkg::READ_PACE_W-1:0] pace_cnt;

	assign last_entry = ring[wr_idx];
	assign release_entry = '{down: 1'b0, code: last_entry.code};
	assign wr_next1 = wr_idx + 1'b1;
	assign wr_next2 = wr_idx + 2'd2;

	// ========================================================================
	// Write side and paced read pointer
	// ========================================================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			for (int i = 0; i < abc80_key_pkg::HIST_DEPTH; i++) begin
				ring[i] <= '0;
			end
			wr_idx <= '0;
			rd_idx <= '0;
			pace_cnt <= '0;
		end else begin
			if (key_update && key_state != last_entry) begin
				if (key_state.down && last_entry.down) begin
					ring[wr_next1] <= release_entry;   // Synthetic key up
					ring[wr_next2] <= key_state;
					wr_idx <= wr_next2;
				end else begin
					ring[wr_next1] <= key_state;
					wr_idx <= wr_next1;
				end
			end

			// No overflow guard, old unread entries get overwritten
			pace_cnt <= pace_cnt + 1'b1;
			if (&pace_cnt && rd_idx != wr_idx)
				rd_idx <= rd_idx + 1'b1;
		end
	end

	assign key_port = ring[rd_idx];

endmodule

`default_nettype wire

// File: design/key_decoder.sv
/*
 * ABC80 key decoder
 * Tracks shift, ctrl and caps lock from PS/2 key events and
 * translates mapped keys to ABC80 character codes with a key-down bit.
 * Signals one update after each strobe has ended.
 */

`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input  logic                      CLK12,
	input  logic                      RESET,
	input  logic                      key_strobe,
	input  ps2_key_pkg::ps2_key_t     key_in,
	output abc80_key_pkg::key_entry_t key_state,
	output logic                      key_update,
	output logic                      upcase
);

	logic       shift;
	logic       ctrl;
	logic       strobe_d;
	logic       letter_hit;
	logic [6:0] letter_base;                   // Upper-case form
	logic       sym_hit;
	logic [13:0] sym_pair;                     // {plain, shifted}
	logic       kp_hit;
	logic [6:0] kp_code;
	logic       map_hit;
	logic [6:0] map_code;

	// ========================================================================
	// Lookup tables, non-extended codes
	// ========================================================================

	always_comb begin
		letter_hit = 1'b1;
		letter_base = 7'h00;
		case (key_in.code)
			8'h1C: letter_base = 7'h41;        // A
			8'h32: letter_base = 7'h42;        // B
			8'h21: letter_base = 7'h43;        // C
			8'h23: letter_base = 7'h44;
			8'h24: letter_base = 7'h45;
			8'h2B: letter_base = 7'h46;
			8'h34: letter_base = 7'h47;
			8'h33: letter_base = 7'h48;
			8'h43: letter_base = 7'h49;
			8'h3B: letter_base = 7'h4A;
			8'h42: letter_base = 7'h4B;
			8'h4B: letter_base = 7'h4C;
			8'h3A: letter_base = 7'h4D;
			8'h31: letter_base = 7'h4E;
			8'h44: letter_base = 7'h4F;
			8'h4D: letter_base = 7'h50;
			8'h15: letter_base = 7'h51;
			8'h2D: letter_base = 7'h52;
			8'h1B: letter_base = 7'h53;
			8'h2C: letter_base = 7'h54;
			8'h3C: letter_base = 7'h55;
			8'h2A: letter_base = 7'h56;
			8'h1D: letter_base = 7'h57;
			8'h22: letter_base = 7'h58;        // X
			8'h35: letter_base = 7'h59;
			8'h1A: letter_base = 7'h5A;        // Z
			8'h55: letter_base = 7'h40;        // National letters from here
			8'h54: letter_base = 7'h5D;
			8'h5B: letter_base = 7'h5E;
			8'h4C: letter_base = 7'h5C;
			8'h52: letter_base = 7'h5B;
			default: letter_hit = 1'b0;
		endcase
	end

	// Digit row and punctuation, plain code then shifted code
	always_comb begin
		sym_hit = 1'b1;
		sym_pair = 14'h0000;
		case (key_in.code)
			8'h16: sym_pair = {7'h31, 7'h21};  // 1 !
			8'h1E: sym_pair = {7'h32, 7'h22};
			8'h26: sym_pair = {7'h33, 7'h23};
			8'h25: sym_pair = {7'h34, 7'h24};
			8'h2E: sym_pair = {7'h35, 7'h25};
			8'h36: sym_pair = {7'h36, 7'h26};
			8'h3D: sym_pair = {7'h37, 7'h2F};  // 7 /
			8'h3E: sym_pair = {7'h38, 7'h28};
			8'h46: sym_pair = {7'h39, 7'h29};
			8'h45: sym_pair = {7'h30, 7'h3D};  // 0 =
			8'h41: sym_pair = {7'h2C, 7'h3B};  // , ;
			8'h49: sym_pair = {7'h2E, 7'h3A};
			8'h4A: sym_pair = {7'h2D, 7'h5F};
			8'h4E: sym_pair = {7'h2B, 7'h3F};
			8'h5D: sym_pair = {7'h27, 7'h2A};
			ps2_key_pkg::SC_GRAVE: sym_pair = {7'h3C, 7'h3E};
			default: sym_hit = 1'b0;
		endcase
	end

	always_comb begin
		kp_hit = 1'b1;
		kp_code = 7'h00;
		case (key_in.code)
			8'h70: kp_code = 7'h30;            // Keypad 0
			8'h69: kp_code = 7'h31;
			8'h72: kp_code = 7'h32;
			8'h7A: kp_code = 7'h33;
			8'h6B: kp_code = 7'h34;
			8'h73: kp_code = 7'h35;
			8'h74: kp_code = 7'h36;
			8'h6C: kp_code = 7'h37;
			8'h75: kp_code = 7'h38;
			8'h7D: kp_code = 7'h39;            // Keypad 9
			default: kp_hit = 1'b0;
		endcase
	end

	// ========================================================================
	// Final code selection
	// ========================================================================

	always_comb begin
		map_hit = 1'b1;
		map_code = 7'h00;
		if (ctrl) begin
			if (!key_in.extended && letter_hit && letter_base == 7'h43)
				map_code = abc80_key_pkg::CH_ETX;
			else if (!key_in.extended && letter_hit && letter_base == 7'h58)
				map_code = abc80_key_pkg::CH_CAN;
			else if (!key_in.extended && letter_hit && letter_base == 7'h41)
				map_code = abc80_key_pkg::CH_SOH;
			else if (!key_in.extended && key_in.code == ps2_key_pkg::SC_GRAVE)
				map_code = abc80_key_pkg::CH_DEL;
			else
				map_hit = 1'b0;
		end else if (!key_in.extended && letter_hit) begin
			map_code = letter_base |
				(shift == upcase ? abc80_key_pkg::CASE_BIT_MASK : 7'h00);
		end else if (!key_in.extended && sym_hit) begin
			map_code = shift ? sym_pair[6:0] : sym_pair[13:7];
		end else if (shift) begin
			map_hit = 1'b0;                    // Rest is unshifted only
		end else if (!key_in.extended && kp_hit) begin
			map_code = kp_code;
		end else begin
			case ({key_in.extended, key_in.code})
				{1'b0, ps2_key_pkg::SC_ENTER},
				{1'b1, ps2_key_pkg::SC_ENTER}: map_code = abc80_key_pkg::CH_CR;
				{1'b0, ps2_key_pkg::SC_SPACE}: map_code = 7'h20;
				{1'b0, ps2_key_pkg::SC_BKSP}: map_code = abc80_key_pkg::CH_BS;
				{1'b1, ps2_key_pkg::SC_LEFT}: map_code = abc80_key_pkg::CH_BS;
				{1'b1, ps2_key_pkg::SC_RIGHT}: map_code = abc80_key_pkg::CH_TAB;
				default: map_hit = 1'b0;
			endcase
		end
	end

	// Modifier and key state
	always_ff @(posedge CLK12) begin
		if (RESET) begin
			shift <= 1'b0;
			ctrl <= 1'b0;
			upcase <= 1'b0;
			strobe_d <= 1'b0;
			key_state <= '0;
		end else begin
			strobe_d <= key_strobe;
			if (key_strobe) begin
				if (!key_in.extended && (key_in.code == ps2_key_pkg::SC_LSHIFT ||
						key_in.code == ps2_key_pkg::SC_RSHIFT))
					shift <= key_in.pressed;
				if (key_in.code == ps2_key_pkg::SC_CTRL)
					ctrl <= key_in.pressed;    // Either ctrl key
				if (!key_in.extended && key_in.code == ps2_key_pkg::SC_CAPS && key_in.pressed)
					upcase <= ~upcase;
				if (map_hit)
					key_state <= '{down: key_in.pressed, code: map_code};
			end
		end
	end

	assign key_update = strobe_d & ~key_strobe;   // Falling edge of strobe

endmodule

`default_nettype wire

// File: design/abc80_key_pkg.sv
/*
 * ABC80 keyboard port definitions
 * Character codes seen by the CPU, the key entry word
 * and the sizing of the key history ring
 */

`default_nettype none

package abc80_key_pkg;

	// ========================================================================
	// Key entry as read on the PIO port A
	// ========================================================================

	typedef struct packed {
		logic       down;                      // Key held
		logic [6:0] code;                      // 7-bit ABC80 character
	} key_entry_t;

	// History ring
	localparam int HIST_DEPTH  = 8;
	localparam int HIST_IDX_W  = 3;
	localparam int READ_PACE_W = 8;            // One read step per 256 clocks

	// Letters are stored upper case, this bit makes them lower case
	localparam logic [6:0] CASE_BIT_MASK = 7'h20;

	// ========================================================================
	// Control characters
	// ========================================================================

	localparam logic [6:0] CH_SOH = 7'h01;     // Ctrl+A
	localparam logic [6:0] CH_ETX = 7'h03;     // Ctrl+C, break
	localparam logic [6:0] CH_BS  = 7'h08;     // Cursor left
	localparam logic [6:0] CH_TAB = 7'h09;     // Cursor right
	localparam logic [6:0] CH_CR  = 7'h0D;
	localparam logic [6:0] CH_CAN = 7'h18;     // Ctrl+X
	localparam logic [6:0] CH_DEL = 7'h7F;

endpackage

`default_nettype wire

// File: design/ps2_key_pkg.sv
/*
 * PS/2 keyboard input definitions
 * Scan codes used by the ABC80 key decoder and the
 * key event word delivered by the host once per strobe
 */

`default_nettype none

package ps2_key_pkg;

	// ========================================================================
	// Incoming key event
	// ========================================================================

	typedef struct packed {
		logic       pressed;                   // 1 = make, 0 = break
		logic       extended;                  // E0 prefix seen
		logic [7:0] code;                      // Set 2 scan code
	} ps2_key_t;

	// ========================================================================
	// Scan codes, set 2
	// ========================================================================

	// Modifiers
	localparam logic [7:0] SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_RSHIFT = 8'h59;
	localparam logic [7:0] SC_CTRL   = 8'h14;  // Left ctrl, right ctrl with E0
	localparam logic [7:0] SC_CAPS   = 8'h58;

	// Editing and layout keys
	localparam logic [7:0] SC_ENTER  = 8'h5A;  // Main and keypad enter
	localparam logic [7:0] SC_SPACE  = 8'h29;
	localparam logic [7:0] SC_BKSP   = 8'h66;
	localparam logic [7:0] SC_GRAVE  = 8'h0E;  // Key left of 1

	// Arrow block, only valid with the extended flag
	// Same codes as keypad 4 and 6 without it
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;

endpackage

`default_nettype wire
